/* hw/tlb_defs.svh */
`ifndef TLB_DEFS_SVH
`define TLB_DEFS_SVH

// Sv32 address and entry widths.
`define VADDR_W 32
`define PADDR_W 34
`define PTE_W 32
`define ASID_W 9

// Bits per VPN level and page offset.
`define VPN_W 10
`define PAGE_OFFSET 12

// Level 0 holds 4 KiB leaves.
`define TLB0_SETS 16
`define TLB0_WAYS 2

// Level 1 holds megapages and pointers.
`define TLB1_SETS 8
`define TLB1_WAYS 2

`endif

/* hw/tlb_pkg.sv */
`include "tlb_defs.svh"

package tlb_pkg;

    typedef logic [`VADDR_W-1:0] vaddr_t;
    typedef logic [`PADDR_W-1:0] paddr_t;

    // ppn1[31:20] ppn0[19:10] rsw[9:8] D A G U X W R V.
    typedef logic [`PTE_W-1:0] pte_t;

    typedef logic [`ASID_W-1:0] asid_t;

    // 0 user, 1 supervisor, 3 machine.
    typedef logic [1:0] priv_t;

    // Zero is fetch, bit 0 load, bit 1 store.
    typedef logic [1:0] source_t;

    typedef enum logic [1:0] {
        IDLE,
        FENCE,
        FENCE_ALL,
        FENCE_END
    } fence_state_t;

endpackage

/* hw/tlb_way.sv */
module tlb_way import tlb_pkg::*; #(
    parameter int TAG_W = 28,
    parameter int SETS  = 16
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    en,
    input  logic                    tag_we,
    input  logic                    pte_we,
    input  logic [$clog2(SETS)-1:0] idx,
    input  logic [TAG_W-1:0]        wtag,
    input  pte_t                    wpte,
    output logic [TAG_W-1:0]        rtag,
    output pte_t                    rpte
);
    logic [SETS-1:0]  valid;
    logic             rvalid;
    logic [TAG_W-2:0] tag_mem [SETS];
    logic [TAG_W-2:0] rbody;
    pte_t             pte_mem [SETS];

    // Valid bits sit in flops so a reset empties the way.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid  <= '0;
            rvalid <= 1'b0;
        end else begin
            if (tag_we) begin
                valid[idx] <= wtag[TAG_W-1];
            end
            if (en) begin
                rvalid <= valid[idx];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tag_we) begin
            tag_mem[idx] <= wtag[TAG_W-2:0];
        end
        if (pte_we) begin
            pte_mem[idx] <= wpte;
        end
        if (en) begin
            rbody <= tag_mem[idx];
            rpte  <= pte_mem[idx];
        end
    end

    assign rtag = {rvalid, rbody};

endmodule

/* hw/pte_check.sv */
module pte_check import tlb_pkg::*; (
    input  pte_t    pte,
    input  source_t source,
    input  priv_t   mode,
    input  logic    sum,
    input  logic    mxr,
    input  logic    mprv,
    input  priv_t   mpp,
    output logic    fault
);
    localparam int PTE_V = 0;
    localparam int PTE_R = 1;
    localparam int PTE_W = 2;
    localparam int PTE_X = 3;
    localparam int PTE_U = 4;
    localparam int PTE_A = 6;
    localparam int PTE_D = 7;

    logic  is_fetch;
    logic  is_load;
    logic  is_store;
    logic  leaf;
    logic  perm_ok;
    logic  priv_bad;
    priv_t eff_mode;

    assign is_store = source[1];
    assign is_load  = source[0];
    assign is_fetch = ~source[0] & ~source[1];
    assign leaf     = pte[PTE_R] | pte[PTE_W] | pte[PTE_X];

    // MPRV only applies to data accesses.
    assign eff_mode = (mprv & ~is_fetch) ? mpp : mode;

    assign perm_ok  = (pte[PTE_R] & is_load) |
                      (pte[PTE_X] & (is_fetch | (is_load & mxr))) |
                      (pte[PTE_W] & is_store);
    assign priv_bad = ((eff_mode == 2'b01) & pte[PTE_U] & ~sum) |
                      ((eff_mode == 2'b00) & ~pte[PTE_U]);

    assign fault = ~pte[PTE_V] | (pte[PTE_W] & ~pte[PTE_R]) | (|pte[9:8]) |
                   (leaf & (~perm_ok | priv_bad | ~pte[PTE_A] | (is_store & ~pte[PTE_D])));

endmodule

/* hw/tlb_page.sv */
`include "tlb_defs.svh"

module tlb_page import tlb_pkg::*; #(
    parameter int LEVEL = 0,
    parameter int WAYS  = `TLB0_WAYS,
    parameter int SETS  = `TLB0_SETS
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   req,
    input  logic   flush,
    input  vaddr_t vaddr,
    input  asid_t  asid,
    input  logic   refill_valid,
    input  logic   refill_level,
    input  vaddr_t refill_vaddr,
    input  pte_t   refill_pte,
    input  logic   fence_req,
    input  logic   fence_all,
    input  vaddr_t fence_vaddr,
    input  asid_t  fence_asid,
    input  logic   fence_asid_all,
    output logic   hit,
    output pte_t   entry,
    output logic   unaligned,
    output logic   fence_busy,
    output logic   fence_done
);
    localparam int IDX_W  = $clog2(SETS);
    localparam int WAY_W  = (WAYS > 1) ? $clog2(WAYS) : 1;
    localparam int IDX_LO = `PAGE_OFFSET + `VPN_W * LEVEL;
    localparam int VTAG_W = `VADDR_W - IDX_LO - IDX_W;
    // Tag word is {valid, vtag, asid, unaligned}.
    localparam int TAG_W  = VTAG_W + `ASID_W + 2;

    fence_state_t      state;
    logic              fence_rd;
    logic              fence_rd_q;
    logic              fence_we;
    logic [IDX_W-1:0]  fence_idx;
    logic [WAYS-1:0]   fence_way;
    logic [VTAG_W-1:0] fence_tag;
    asid_t             fence_asid_q;
    logic              fence_asid_all_q;
    logic              req_q;
    logic [VTAG_W-1:0] tag_q;
    asid_t             cmp_asid;
    logic              rd_en;
    logic              refill_wr;
    logic              refill_unal;
    logic [IDX_W-1:0]  refill_idx;
    logic [IDX_W-1:0]  way_idx;
    logic [WAY_W-1:0]  repl [SETS];
    logic [WAYS-1:0]   refill_way;
    logic [WAYS-1:0]   tag_hits;
    logic [TAG_W-1:0]  wtag;
    logic [TAG_W-1:0]  rtag [WAYS];
    pte_t              rpte [WAYS];

    function automatic logic [IDX_W-1:0] idx_of(vaddr_t va);
        return va[IDX_LO +: IDX_W];
    endfunction

    function automatic logic [VTAG_W-1:0] vtag_of(vaddr_t va);
        return va[IDX_LO + IDX_W +: VTAG_W];
    endfunction

    ////////////////////
    // Array access

    assign refill_wr   = refill_valid & (refill_level == 1'(LEVEL)) & ~fence_rd & ~fence_we;
    assign refill_idx  = idx_of(refill_vaddr);
    assign refill_unal = (LEVEL != 0) & (|refill_pte[3:1]) & (|refill_pte[19:10]);
    assign rd_en       = req | fence_rd;
    assign way_idx     = (fence_rd | fence_we) ? fence_idx :
                         refill_valid ? refill_idx : idx_of(vaddr);
    assign wtag        = fence_we ? '0 : {1'b1, vtag_of(refill_vaddr), asid, refill_unal};
    assign cmp_asid    = fence_rd_q ? fence_asid_q : asid;

    for (genvar i = 0; i < WAYS; i++) begin : g_way
        assign refill_way[i] = refill_wr & (repl[refill_idx] == WAY_W'(i));

        tlb_way #(
            .TAG_W(TAG_W),
            .SETS (SETS)
        ) u_way (
            .clk   (clk),
            .rst   (rst),
            .en    (rd_en),
            .tag_we(refill_way[i] | (fence_we & fence_way[i])),
            .pte_we(refill_way[i]),
            .idx   (way_idx),
            .wtag  (wtag),
            .wpte  (refill_pte),
            .rtag  (rtag[i]),
            .rpte  (rpte[i])
        );

        assign tag_hits[i] = rtag[i][TAG_W-1] & (rtag[i][TAG_W-2 -: VTAG_W] == tag_q) &
                             ((rtag[i][`ASID_W:1] == cmp_asid) |
                              (fence_rd_q & fence_asid_all_q));
    end

    // Lowest way wins on a multiple hit.
    always_comb begin
        entry     = rpte[0];
        unaligned = rtag[0][0];
        for (int i = WAYS - 1; i >= 0; i--) begin
            if (tag_hits[i]) begin
                entry     = rpte[i];
                unaligned = rtag[i][0];
            end
        end
    end

    assign hit = req_q & (|tag_hits);

    // Round robin per set.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                repl[s] <= '0;
            end
        end else if (refill_wr) begin
            repl[refill_idx] <= (repl[refill_idx] == WAY_W'(WAYS - 1)) ? '0 :
                                repl[refill_idx] + 1'b1;
        end
    end

    ////////////////////
    // Fence

    assign fence_busy = fence_req | (state != IDLE);

    always_ff @(posedge clk) begin
        tag_q <= fence_rd ? fence_tag : vtag_of(vaddr);
        if (state == IDLE && fence_req) begin
            fence_tag        <= vtag_of(fence_vaddr);
            fence_asid_q     <= fence_asid;
            fence_asid_all_q <= fence_asid_all;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= IDLE;
            req_q      <= 1'b0;
            fence_rd   <= 1'b0;
            fence_rd_q <= 1'b0;
            fence_we   <= 1'b0;
            fence_idx  <= '0;
            fence_way  <= '0;
            fence_done <= 1'b0;
        end else begin
            req_q      <= req & ~flush;
            fence_rd_q <= fence_rd;
            fence_done <= (state == FENCE_END);
            case (state)
                IDLE: begin
                    if (fence_req) begin
                        if (fence_all) begin
                            fence_idx <= '0;
                            fence_we  <= 1'b1;
                            fence_way <= '1;
                            state     <= FENCE_ALL;
                        end else begin
                            fence_idx <= idx_of(fence_vaddr);
                            fence_rd  <= 1'b1;
                            state     <= FENCE;
                        end
                    end
                end
                FENCE: begin
                    fence_rd <= 1'b0;
                    // Tags read last cycle; clear whatever matched.
                    if (fence_rd_q) begin
                        fence_we  <= |tag_hits;
                        fence_way <= tag_hits;
                        state     <= FENCE_END;
                    end
                end
                FENCE_ALL: begin
                    fence_idx <= fence_idx + 1'b1;
                    if (fence_idx == IDX_W'(SETS - 2)) begin
                        state <= FENCE_END;
                    end
                end
                FENCE_END: begin
                    fence_we <= 1'b0;
                    state    <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

/* hw/tlb_cache.sv */
`include "tlb_defs.svh"

module tlb_cache import tlb_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    req,
    input  vaddr_t  req_vaddr,
    input  source_t req_source,
    input  logic    flush,
    input  asid_t   asid,
    input  priv_t   mode,
    input  logic    sum,
    input  logic    mxr,
    input  logic    mprv,
    input  priv_t   mpp,
    input  logic    refill_valid,
    input  logic    refill_level,
    input  vaddr_t  refill_vaddr,
    input  pte_t    refill_pte,
    input  logic    ptw_busy,
    input  logic    fence_req,
    input  logic    fence_all,
    input  vaddr_t  fence_vaddr,
    input  asid_t   fence_asid,
    input  logic    fence_asid_all,
    output logic    resp_valid,
    output logic    resp_error,
    output logic    resp_exception,
    output logic    resp_mega,
    output paddr_t  resp_paddr,
    output logic    miss_valid,
    output vaddr_t  miss_vaddr,
    output source_t miss_source,
    output logic    miss_level,
    output paddr_t  miss_ptr,
    output logic    fence_done
);
    logic    req_q;
    vaddr_t  vaddr_q;
    source_t source_q;
    logic    hit0, hit1, unal1, fence_busy;
    pte_t    entry0, entry1;
    logic    fault0, fault1;
    logic    sel0, sel1, walk, blocked;
    logic    resp_valid_q, miss_valid_q;
    paddr_t  paddr0, paddr1, ptr;

    tlb_page #(.LEVEL(0), .WAYS(`TLB0_WAYS), .SETS(`TLB0_SETS)) u_page0 (
        .*,
        .vaddr(req_vaddr), .hit(hit0), .entry(entry0), .unaligned(),
        .fence_busy(fence_busy), .fence_done(fence_done)
    );

    // Level 1 fences never outlast level 0.
    tlb_page #(.LEVEL(1), .WAYS(`TLB1_WAYS), .SETS(`TLB1_SETS)) u_page1 (
        .*,
        .vaddr(req_vaddr), .hit(hit1), .entry(entry1), .unaligned(unal1),
        .fence_busy(), .fence_done()
    );

    pte_check u_check0 (.*, .pte(entry0), .source(source_q), .fault(fault0));
    pte_check u_check1 (.*, .pte(entry1), .source(source_q), .fault(fault1));

    ////////////////////
    // Stage 1

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_q <= 1'b0;
        end else begin
            req_q <= req & ~flush;
        end
    end

    always_ff @(posedge clk) begin
        vaddr_q  <= req_vaddr;
        source_q <= req_source;
    end

    // Level 0 first, then a megapage, then a pointer for the walker.
    assign sel0    = hit0 & ((|entry0[3:1]) | fault0);
    assign sel1    = ~sel0 & hit1 & ((|entry1[3:1]) | fault1);
    assign walk    = ~sel0 & hit1 & ~(|entry1[3:1]) & ~fault1;
    assign blocked = ptw_busy | fence_busy;

    assign paddr0 = {entry0[`PTE_W-1:10], vaddr_q[`PAGE_OFFSET-1:0]};
    assign paddr1 = {entry1[`PTE_W-1:20], vaddr_q[`PAGE_OFFSET +: `VPN_W],
                     vaddr_q[`PAGE_OFFSET-1:0]};
    assign ptr    = {entry1[`PTE_W-1:10], vaddr_q[`PAGE_OFFSET +: `VPN_W], 2'b00};

    ////////////////////
    // Stage 2

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            resp_valid_q <= 1'b0;
            miss_valid_q <= 1'b0;
        end else begin
            resp_valid_q <= req_q & ~flush & (sel0 | sel1 | blocked);
            miss_valid_q <= req_q & ~flush & ~sel0 & ~sel1 & ~blocked;
        end
    end

    always_ff @(posedge clk) begin
        resp_error     <= ~sel0 & ~sel1;
        resp_exception <= (sel0 & fault0) | (sel1 & (fault1 | unal1));
        resp_mega      <= sel1;
        resp_paddr     <= sel0 ? paddr0 : paddr1;
        miss_vaddr     <= vaddr_q;
        miss_source    <= source_q;
        miss_level     <= ~walk;
        miss_ptr       <= ptr;
    end

    assign resp_valid = resp_valid_q & ~flush;
    assign miss_valid = miss_valid_q & ~flush;

endmodule

/* sim/tlb_cache_tb.sv */
`include "tlb_defs.svh"

module tlb_cache_tb import tlb_pkg::*; ();

    localparam int CLK_PERIOD      = 8;
    localparam int WATCHDOG_CYCLES = 4000;
    localparam int FENCE_LIMIT     = 4 * `TLB0_SETS;

    localparam source_t SRC_FETCH = 2'b00;
    localparam source_t SRC_LOAD  = 2'b01;
    localparam source_t SRC_STORE = 2'b10;

    logic    clk, rst, req, flush, sum, mxr, mprv, ptw_busy;
    logic    refill_valid, refill_level, fence_req, fence_all, fence_asid_all;
    vaddr_t  req_vaddr, refill_vaddr, fence_vaddr;
    source_t req_source;
    asid_t   asid, fence_asid;
    priv_t   mode, mpp;
    pte_t    refill_pte;
    logic    resp_valid, resp_error, resp_exception, resp_mega;
    logic    miss_valid, miss_level, fence_done;
    paddr_t  resp_paddr, miss_ptr;
    vaddr_t  miss_vaddr;
    source_t miss_source;

    int seed = 32'h832e;
    int fences_sent = 0;
    int done_count = 0;

    tlb_cache uut (.*);

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(negedge clk) begin
        if (fence_done) begin
            done_count++;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        stop_with_failure();
    end

    ////////////////////
    // Helpers

    task automatic stop_with_failure();
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_with_failure();
        end
    endtask

    function automatic vaddr_t make_va(input logic [9:0] vpn1, input logic [9:0] vpn0);
        logic [31:0] r;
        r = $random(seed);
        return {vpn1, vpn0, r[11:0]};
    endfunction

    function automatic pte_t leaf_pte(input logic [7:0] flags);
        logic [31:0] r;
        r = $random(seed);
        return {r[31:10], 2'b00, flags};
    endfunction

    function automatic pte_t megapage_pte(input logic [7:0] flags);
        logic [31:0] r;
        r = $random(seed);
        return {r[31:20], 10'h000, 2'b00, flags};
    endfunction

    // Nonzero ppn0, so a megapage built from it is misaligned.
    function automatic pte_t misaligned_pte(input logic [7:0] flags);
        logic [31:0] r;
        r = $random(seed);
        return {r[31:20], r[19:11], 1'b1, 2'b00, flags};
    endfunction

    function automatic paddr_t page_paddr(input pte_t pte, input vaddr_t va);
        return {pte[31:10], va[11:0]};
    endfunction

    function automatic paddr_t mega_paddr(input pte_t pte, input vaddr_t va);
        return {pte[31:20], va[21:12], va[11:0]};
    endfunction

    function automatic paddr_t walk_ptr(input pte_t pte, input vaddr_t va);
        return (paddr_t'(pte[31:10]) << 12) + (paddr_t'(va[21:12]) << 2);
    endfunction

    task automatic refill_entry(input logic level, input vaddr_t va, input pte_t pte);
        refill_valid = 1'b1;
        refill_level = level;
        refill_vaddr = va;
        refill_pte   = pte;
        @(negedge clk);
        refill_valid = 1'b0;
    endtask

    // Returns in the cycle where the response is due.
    task automatic issue_lookup(input vaddr_t va, input source_t src);
        req        = 1'b1;
        req_vaddr  = va;
        req_source = src;
        @(negedge clk);
        req = 1'b0;
        @(negedge clk);
    endtask

    task automatic lookup_hits(input vaddr_t va, input source_t src, input paddr_t paddr,
                               input logic mega, input logic exc);
        issue_lookup(va, src);
        check_value("resp_valid", 64'(resp_valid), 64'(1));
        check_value("miss_valid", 64'(miss_valid), 64'(0));
        check_value("resp_error", 64'(resp_error), 64'(0));
        check_value("resp_exception", 64'(resp_exception), 64'(exc));
        check_value("resp_mega", 64'(resp_mega), 64'(mega));
        if (!exc) begin
            check_value("resp_paddr", 64'(resp_paddr), 64'(paddr));
        end
    endtask

    task automatic lookup_misses(input vaddr_t va, input source_t src, input logic level,
                                 input paddr_t ptr);
        issue_lookup(va, src);
        check_value("resp_valid", 64'(resp_valid), 64'(0));
        check_value("miss_valid", 64'(miss_valid), 64'(1));
        check_value("miss_vaddr", 64'(miss_vaddr), 64'(va));
        check_value("miss_source", 64'(miss_source), 64'(src));
        check_value("miss_level", 64'(miss_level), 64'(level));
        if (!level) begin
            check_value("miss_ptr", 64'(miss_ptr), 64'(ptr));
        end
    endtask

    task automatic run_fence(input logic all, input vaddr_t va, input asid_t fasid,
                             input logic fasid_all);
        int waited;
        fence_req      = 1'b1;
        fence_all      = all;
        fence_vaddr    = va;
        fence_asid     = fasid;
        fence_asid_all = fasid_all;
        fences_sent++;
        @(negedge clk);
        fence_req = 1'b0;
        waited    = 0;
        while (!fence_done) begin
            if (waited == FENCE_LIMIT) begin
                $display("Fence did not complete within %0d cycles", FENCE_LIMIT);
                stop_with_failure();
            end
            @(negedge clk);
            waited++;
        end
        @(negedge clk);
        check_value("fence_done", 64'(fence_done), 64'(0));
        check_value("fence_done pulses", 64'(done_count), 64'(fences_sent));
    endtask

    ////////////////////
    // Tests

    task automatic reset_and_cold_miss();
        check_value("resp_valid", 64'(resp_valid), 64'(0));
        check_value("miss_valid", 64'(miss_valid), 64'(0));
        check_value("fence_done", 64'(fence_done), 64'(0));
        lookup_misses(make_va(10'h001, 10'h3ff), SRC_STORE, 1'b1, '0);
    endtask

    task automatic page_refill_and_replacement();
        vaddr_t a, b, c;
        pte_t   pa, pb, pc;
        a  = make_va(10'h002, {6'h01, 4'h3});
        b  = make_va(10'h002, {6'h02, 4'h3});
        c  = make_va(10'h002, {6'h03, 4'h3});
        pa = leaf_pte(8'hcf);
        pb = leaf_pte(8'hcf);
        pc = leaf_pte(8'hcf);
        refill_entry(1'b0, a, pa);
        lookup_hits(a, SRC_LOAD, page_paddr(pa, a), 1'b0, 1'b0);
        asid = 9'h006;
        lookup_misses(a, SRC_LOAD, 1'b1, '0);
        asid = 9'h005;
        // Third refill to set 3 lands on the first way again.
        refill_entry(1'b0, b, pb);
        refill_entry(1'b0, c, pc);
        lookup_misses(a, SRC_LOAD, 1'b1, '0);
        lookup_hits(b, SRC_LOAD, page_paddr(pb, b), 1'b0, 1'b0);
        lookup_hits(c, SRC_LOAD, page_paddr(pc, c), 1'b0, 1'b0);
    endtask

    task automatic megapages_and_pointers();
        vaddr_t va;
        pte_t   pte, lpte;
        va  = make_va(10'h040, 10'h123);
        pte = megapage_pte(8'hcf);
        refill_entry(1'b1, va, pte);
        va = make_va(10'h040, 10'h2a5);
        lookup_hits(va, SRC_LOAD, mega_paddr(pte, va), 1'b1, 1'b0);
        va  = make_va(10'h041, 10'h011);
        refill_entry(1'b1, va, misaligned_pte(8'hcf));
        lookup_hits(va, SRC_LOAD, '0, 1'b1, 1'b1);
        va  = make_va(10'h042, 10'h155);
        pte = leaf_pte(8'h01);
        refill_entry(1'b1, va, pte);
        lookup_misses(va, SRC_LOAD, 1'b0, walk_ptr(pte, va));
        va   = make_va(10'h043, 10'h005);
        lpte = leaf_pte(8'hcf);
        refill_entry(1'b1, va, megapage_pte(8'hcf));
        refill_entry(1'b0, va, lpte);
        lookup_hits(va, SRC_LOAD, page_paddr(lpte, va), 1'b0, 1'b0);
    endtask

    task automatic permission_faults();
        vaddr_t va;
        pte_t   pte;
        va  = make_va(10'h080, {6'h00, 4'h8});
        pte = leaf_pte(8'hc3);
        refill_entry(1'b0, va, pte);
        lookup_hits(va, SRC_STORE, page_paddr(pte, va), 1'b0, 1'b1);
        lookup_hits(va, SRC_LOAD, page_paddr(pte, va), 1'b0, 1'b0);
        va  = make_va(10'h080, {6'h00, 4'h9});
        pte = leaf_pte(8'hd3);
        refill_entry(1'b0, va, pte);
        lookup_hits(va, SRC_LOAD, page_paddr(pte, va), 1'b0, 1'b1);
        sum = 1'b1;
        lookup_hits(va, SRC_LOAD, page_paddr(pte, va), 1'b0, 1'b0);
        sum = 1'b0;
        va  = make_va(10'h080, {6'h00, 4'ha});
        pte = leaf_pte(8'hc9);
        refill_entry(1'b0, va, pte);
        lookup_hits(va, SRC_LOAD, page_paddr(pte, va), 1'b0, 1'b1);
        lookup_hits(va, SRC_FETCH, page_paddr(pte, va), 1'b0, 1'b0);
        mxr = 1'b1;
        lookup_hits(va, SRC_LOAD, page_paddr(pte, va), 1'b0, 1'b0);
        mxr = 1'b0;
        va  = make_va(10'h080, {6'h00, 4'hb});
        pte = leaf_pte(8'h87);
        refill_entry(1'b0, va, pte);
        lookup_hits(va, SRC_LOAD, page_paddr(pte, va), 1'b0, 1'b1);
        va  = make_va(10'h080, {6'h00, 4'hc});
        pte = leaf_pte(8'h47);
        refill_entry(1'b0, va, pte);
        lookup_hits(va, SRC_STORE, page_paddr(pte, va), 1'b0, 1'b1);
        lookup_hits(va, SRC_LOAD, page_paddr(pte, va), 1'b0, 1'b0);
        // Supervisor page seen through user mode for data only.
        va  = make_va(10'h080, {6'h00, 4'hd});
        pte = leaf_pte(8'hcf);
        refill_entry(1'b0, va, pte);
        mprv = 1'b1;
        mpp  = 2'b00;
        lookup_hits(va, SRC_LOAD, page_paddr(pte, va), 1'b0, 1'b1);
        lookup_hits(va, SRC_FETCH, page_paddr(pte, va), 1'b0, 1'b0);
        mprv = 1'b0;
    endtask

    task automatic backpressure_and_flush();
        vaddr_t a, b;
        pte_t   pa;
        a  = make_va(10'h0c0, {6'h01, 4'h2});
        b  = make_va(10'h0c1, {6'h01, 4'h2});
        pa = leaf_pte(8'hcf);
        refill_entry(1'b0, a, pa);
        ptw_busy = 1'b1;
        issue_lookup(b, SRC_LOAD);
        ptw_busy = 1'b0;
        check_value("resp_valid", 64'(resp_valid), 64'(1));
        check_value("resp_error", 64'(resp_error), 64'(1));
        check_value("miss_valid", 64'(miss_valid), 64'(0));
        req       = 1'b1;
        req_vaddr = a;
        @(negedge clk);
        req   = 1'b0;
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        check_value("resp_valid", 64'(resp_valid), 64'(0));
        check_value("miss_valid", 64'(miss_valid), 64'(0));
        @(negedge clk);
        check_value("resp_valid", 64'(resp_valid), 64'(0));
        check_value("miss_valid", 64'(miss_valid), 64'(0));
        req       = 1'b1;
        req_vaddr = a;
        @(negedge clk);
        req_vaddr = b;
        @(negedge clk);
        req = 1'b0;
        check_value("resp_valid", 64'(resp_valid), 64'(1));
        check_value("miss_valid", 64'(miss_valid), 64'(0));
        check_value("resp_paddr", 64'(resp_paddr), 64'(page_paddr(pa, a)));
        @(negedge clk);
        check_value("resp_valid", 64'(resp_valid), 64'(0));
        check_value("miss_valid", 64'(miss_valid), 64'(1));
        check_value("miss_vaddr", 64'(miss_vaddr), 64'(b));
    endtask

    task automatic fence_removal();
        vaddr_t x, y, z, m;
        pte_t   py, pm;
        x  = make_va(10'h100, {6'h01, 4'h7});
        y  = make_va(10'h100, {6'h02, 4'h7});
        z  = make_va(10'h100, {6'h03, 4'he});
        m  = make_va(10'h101, 10'h0f0);
        py = leaf_pte(8'hcf);
        pm = megapage_pte(8'hcf);
        refill_entry(1'b0, x, leaf_pte(8'hcf));
        refill_entry(1'b0, y, py);
        // Fence ASID differs from the CSR ASID.
        asid = 9'h006;
        run_fence(1'b0, x, 9'h005, 1'b0);
        asid = 9'h005;
        lookup_misses(x, SRC_LOAD, 1'b1, '0);
        lookup_hits(y, SRC_LOAD, page_paddr(py, y), 1'b0, 1'b0);
        // Same page under two ASIDs and a fence for any ASID.
        refill_entry(1'b0, z, leaf_pte(8'hcf));
        asid = 9'h006;
        refill_entry(1'b0, z, leaf_pte(8'hcf));
        run_fence(1'b0, z, 9'h007, 1'b1);
        lookup_misses(z, SRC_LOAD, 1'b1, '0);
        asid = 9'h005;
        lookup_misses(z, SRC_LOAD, 1'b1, '0);
        refill_entry(1'b1, m, pm);
        lookup_hits(m, SRC_LOAD, mega_paddr(pm, m), 1'b1, 1'b0);
        run_fence(1'b1, '0, '0, 1'b0);
        lookup_misses(y, SRC_LOAD, 1'b1, '0);
        lookup_misses(m, SRC_LOAD, 1'b1, '0);
    endtask

    initial begin
        rst            = 1'b1;
        req            = 1'b0;
        req_vaddr      = '0;
        req_source     = SRC_LOAD;
        flush          = 1'b0;
        asid           = 9'h005;
        mode           = 2'b01;
        sum            = 1'b0;
        mxr            = 1'b0;
        mprv           = 1'b0;
        mpp            = 2'b00;
        refill_valid   = 1'b0;
        refill_level   = 1'b0;
        refill_vaddr   = '0;
        refill_pte     = '0;
        ptw_busy       = 1'b0;
        fence_req      = 1'b0;
        fence_all      = 1'b0;
        fence_vaddr    = '0;
        fence_asid     = '0;
        fence_asid_all = 1'b0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        reset_and_cold_miss();
        page_refill_and_replacement();
        megapages_and_pointers();
        permission_faults();
        backpressure_and_flush();
        fence_removal();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* tlb_cache.f */
+incdir+hw
hw/tlb_pkg.sv
hw/tlb_way.sv
hw/pte_check.sv
hw/tlb_page.sv
hw/tlb_cache.sv
sim/tlb_cache_tb.sv

/* run.sh */
#!/bin/sh
# Builds the TLB cache testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module tlb_cache_tb -f tlb_cache.f -o tlb_cache_sim; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tlb_cache_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi
exit 0
